//--- list.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/issue_if.sv
rtl/inst_fetch.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/issue_stage.sv
rtl/ex_unit.sv
rtl/cpu_pipeline.sv
verif/tb_clock.sv
verif/cpu_pipeline_tb.sv

//--- Bender.yml
package:
  name: cpu_pipeline

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_pkg.sv
      - rtl/issue_if.sv
      - rtl/inst_fetch.sv
      - rtl/inst_decoder.sv
      - rtl/reg_file.sv
      - rtl/issue_stage.sv
      - rtl/ex_unit.sv
      - rtl/cpu_pipeline.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/tb_clock.sv
      - verif/cpu_pipeline_tb.sv

//--- verif/cpu_pipeline_tb.sv
// testbench for the core: Wishbone memory models, a small assembler and directed program tests
`include "rv_macros.svh"

module cpu_pipeline_tb import rv_pkg::*; ();

    localparam int    NUM_TESTS       = 5;
    localparam int    CYCLES_PER_TEST = 2000;
    localparam int    MEM_WORDS       = 256;
    localparam int    LOOP_COUNT      = 9;
    // a store here ends a test program
    localparam word_t MARKER_ADDR     = 32'h0000_03fc;

    logic  clk;
    logic  rst;
    logic  reset_req = 1'b0;
    logic  ibus_cyc, ibus_stb;
    word_t ibus_adr;
    word_t ibus_rdata = '0;
    logic  ibus_ack = 1'b0;
    logic  dbus_cyc, dbus_stb, dbus_we;
    word_t dbus_adr, dbus_wdata;
    word_t dbus_rdata = '0;
    logic  dbus_ack = 1'b0;

    // separate instruction and data spaces, both indexed by address bits 9:2
    word_t       rom [MEM_WORDS];
    word_t       ram [MEM_WORDS];
    logic [1:0]  ibus_wait, dbus_wait;
    logic [31:0] seed = 32'd78047;
    logic        rom_random_wait = 1'b0;
    logic        marker_seen;

    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_val [$];
    word_t slot;

    tb_clock clock_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .rst       (rst)
    );

    cpu_pipeline DUT (
        .clk        (clk),
        .rst        (rst),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_rdata (ibus_rdata),
        .ibus_ack   (ibus_ack),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_wdata (dbus_wdata),
        .dbus_rdata (dbus_rdata),
        .dbus_ack   (dbus_ack)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
    endfunction

    // instruction encoders
    function automatic word_t r_op(input logic [6:0] f7, input logic [2:0] f3,
                                   input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
    endfunction

    function automatic word_t i_op(input logic [2:0] f3, input int rd, input int rs1,
                                   input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], `OPC_OP_IMM};
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], `OPC_LOAD};
    endfunction

    function automatic word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OPC_STORE};
    endfunction

    function automatic word_t lui(input int rd, input word_t upper);
        return {upper[19:0], rd[4:0], `OPC_LUI};
    endfunction

    function automatic word_t branch(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic word_t jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OPC_JAL};
    endfunction

    function automatic logic branch_taken(input br_cond_t cond, input word_t a, input word_t b);
        case (cond)
            `BR_EQ:  return a == b;
            `BR_NE:  return a != b;
            `BR_LT:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    // Wishbone classic slaves, ack registered for one cycle
    always @(posedge clk) begin
        if (!rst) begin
            ibus_ack    <= 1'b0;
            dbus_ack    <= 1'b0;
            ibus_wait   <= '0;
            dbus_wait   <= '0;
            marker_seen <= 1'b0;
        end else begin
            if (ibus_ack) begin
                ibus_ack <= 1'b0;
            end else if (ibus_cyc && ibus_stb) begin
                if (ibus_wait == 0) begin
                    ibus_ack   <= 1'b1;
                    ibus_rdata <= rom[ibus_adr[9:2]];
                    seed = lcg_next(seed);
                    ibus_wait  <= rom_random_wait ? seed[31:30] : 2'd0;
                end else begin
                    ibus_wait <= ibus_wait - 2'd1;
                end
            end
            if (dbus_ack) begin
                dbus_ack <= 1'b0;
            end else if (dbus_cyc && dbus_stb) begin
                if (dbus_wait == 0) begin
                    dbus_ack   <= 1'b1;
                    dbus_rdata <= ram[dbus_adr[9:2]];
                    if (dbus_we) begin
                        ram[dbus_adr[9:2]] <= dbus_wdata;
                        marker_seen <= marker_seen || (dbus_adr == MARKER_ADDR);
                    end
                    seed = lcg_next(seed);
                    dbus_wait <= seed[31:30];
                end else begin
                    dbus_wait <= dbus_wait - 2'd1;
                end
            end
        end
    end

    task automatic check_equal(input word_t got, input word_t expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic begin_program();
        prog.delete();
        exp_addr.delete();
        exp_val.delete();
        slot = 32'h100;
    endtask

    // store a register to the next result slot and note what it must hold
    task automatic store_expect(input int rs, input word_t value);
        prog.push_back(sw(rs, 0, slot));
        exp_addr.push_back(slot);
        exp_val.push_back(value);
        slot += 4;
    endtask

    task automatic load_const(input int rd, input word_t value);
        word_t upper;
        upper = (value + 32'h800) >> 12;
        prog.push_back(lui(rd, upper));
        prog.push_back(i_op(3'b000, rd, rd, int'(value[11:0])));
    endtask

    task automatic load_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = (i < prog.size()) ? prog[i] : '0;
            ram[i] = fill_word(i * 4);
        end
    endtask

    task automatic check_reset_and_first_fetch();
        @(negedge clk);
        check_equal(ibus_cyc, 1'b0, "ibus_cyc during reset");
        check_equal(dbus_cyc, 1'b0, "dbus_cyc during reset");
        wait (rst == 1'b1);
        @(posedge clk);
        @(negedge clk);
        check_equal(ibus_cyc, 1'b1, "ibus_cyc on first cycle after reset");
        check_equal(ibus_adr, `RESET_PC, "first fetch address");
    endtask

    // ends the program with the marker store and a self loop, then runs it
    task automatic run_program(input logic random_fetch_wait);
        prog.push_back(sw(0, 0, MARKER_ADDR));
        prog.push_back(jal(0, 0));
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        wait (rst == 1'b0);
        rom_random_wait = random_fetch_wait;
        load_memories();
        check_reset_and_first_fetch();
        while (!marker_seen) begin
            @(posedge clk);
        end
        @(negedge clk);
        foreach (exp_addr[i]) begin
            check_equal(ram[exp_addr[i][9:2]], exp_val[i],
                        $sformatf("word at address %h", exp_addr[i]));
        end
    endtask

    task automatic alu_case(input word_t inst, input word_t expected);
        prog.push_back(inst);
        store_expect(3, expected);
    endtask

    task automatic branch_case(input br_cond_t cond, input int ra, input int rb,
                               input word_t va, input word_t vb);
        prog.push_back(branch(cond, ra, rb, 8));
        // the store right behind a taken branch must leave the fill word
        store_expect(ra, branch_taken(cond, va, vb) ? fill_word(slot) : va);
    endtask

    task automatic test_alu_ops();
        word_t a, b;
        a = 32'hf0f0_1234;
        b = 32'h0000_0ff3;
        begin_program();
        load_const(1, a);
        load_const(2, b);
        alu_case(r_op(7'h00, 3'b000, 3, 1, 2), a + b);
        alu_case(r_op(7'h20, 3'b000, 3, 1, 2), a - b);
        alu_case(r_op(7'h00, 3'b111, 3, 1, 2), a & b);
        alu_case(r_op(7'h00, 3'b110, 3, 1, 2), a | b);
        alu_case(r_op(7'h00, 3'b100, 3, 1, 2), a ^ b);
        alu_case(r_op(7'h00, 3'b010, 3, 1, 2), word_t'($signed(a) < $signed(b)));
        alu_case(r_op(7'h00, 3'b011, 3, 1, 2), word_t'(a < b));
        alu_case(r_op(7'h00, 3'b001, 3, 1, 2), a << b[4:0]);
        alu_case(r_op(7'h00, 3'b101, 3, 1, 2), a >> b[4:0]);
        alu_case(r_op(7'h20, 3'b101, 3, 1, 2), word_t'($signed(a) >>> b[4:0]));
        alu_case(i_op(3'b000, 3, 1, -5), a - 32'd5);
        alu_case(i_op(3'b111, 3, 1, 12'h7f0), a & 32'h0000_07f0);
        alu_case(i_op(3'b110, 3, 1, -256), a | 32'hffff_ff00);
        alu_case(i_op(3'b100, 3, 1, 12'h5a5), a ^ 32'h0000_05a5);
        // negative against positive, so signed and unsigned differ
        alu_case(i_op(3'b010, 3, 1, 5), word_t'($signed(a) < 5));
        alu_case(lui(3, 32'habcde), 32'habcd_e000);
        run_program(1'b0);
    endtask

    task automatic test_forwarding();
        word_t v2, v3, v4, v6, v7;
        v2 = 32'd5 + 32'd7;
        v3 = v2 + 32'd5;
        v4 = v3 - v2;
        v6 = v4 ^ v3;
        v7 = v6 << 5;
        begin_program();
        prog.push_back(i_op(3'b000, 1, 0, 5));
        prog.push_back(i_op(3'b000, 2, 1, 7));
        prog.push_back(r_op(7'h00, 3'b000, 3, 2, 1));
        prog.push_back(r_op(7'h20, 3'b000, 4, 3, 2));
        // a write to x0 right before a read of x0
        prog.push_back(i_op(3'b000, 0, 4, 99));
        prog.push_back(r_op(7'h00, 3'b000, 5, 0, 4));
        prog.push_back(r_op(7'h00, 3'b100, 6, 5, 3));
        prog.push_back(r_op(7'h00, 3'b001, 7, 6, 1));
        store_expect(7, v7);
        store_expect(0, 32'd0);
        store_expect(5, v4);
        store_expect(6, v6);
        store_expect(3, v3);
        run_program(1'b0);
    endtask

    task automatic test_load_use();
        word_t sum;
        sum = '0;
        begin_program();
        for (int i = 0; i < 4; i++) begin
            prog.push_back(lw(1 + i, 0, 32'h80 + 4 * i));
            prog.push_back(r_op(7'h00, 3'b000, 10, 10, 1 + i));
            sum += fill_word(32'h80 + 4 * i);
        end
        store_expect(10, sum);
        // read back the word just stored and use it at once
        prog.push_back(lw(11, 0, slot - 4));
        prog.push_back(i_op(3'b000, 11, 11, 1));
        store_expect(11, sum + 32'd1);
        run_program(1'b0);
    endtask

    task automatic test_branches();
        word_t link;
        begin_program();
        prog.push_back(i_op(3'b000, 1, 0, 3));
        prog.push_back(i_op(3'b000, 2, 0, 3));
        prog.push_back(i_op(3'b000, 3, 0, -1));
        branch_case(`BR_EQ, 1, 2, 32'd3, 32'd3);
        branch_case(`BR_EQ, 1, 3, 32'd3, 32'hffff_ffff);
        branch_case(`BR_NE, 1, 2, 32'd3, 32'd3);
        branch_case(`BR_NE, 1, 3, 32'd3, 32'hffff_ffff);
        branch_case(`BR_LT, 3, 1, 32'hffff_ffff, 32'd3);
        branch_case(`BR_LT, 1, 3, 32'd3, 32'hffff_ffff);
        branch_case(`BR_GE, 1, 3, 32'd3, 32'hffff_ffff);
        branch_case(`BR_GE, 3, 1, 32'hffff_ffff, 32'd3);
        branch_case(`BR_GE, 1, 2, 32'd3, 32'd3);
        link = prog.size() * 4 + 4;
        prog.push_back(jal(5, 8));
        store_expect(1, fill_word(slot));
        store_expect(5, link);
        run_program(1'b0);
    endtask

    task automatic test_loop();
        begin_program();
        prog.push_back(i_op(3'b000, 2, 0, LOOP_COUNT));
        prog.push_back(i_op(3'b000, 1, 1, 1));
        prog.push_back(i_op(3'b000, 3, 3, 3));
        prog.push_back(branch(`BR_NE, 1, 2, -8));
        store_expect(1, LOOP_COUNT);
        store_expect(3, 3 * LOOP_COUNT);
        run_program(1'b1);
    endtask

    initial begin
        test_alu_ops();
        test_forwarding();
        test_load_use();
        test_branches();
        test_loop();
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: a test program did not reach its final store in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verif/tb_clock.sv
// testbench clock and reset source, reset is held low again after every request
module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    int unsigned held = 0;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // rst low until enough cycles have passed since the last request
    always @(posedge clk) begin
        if (reset_req) begin
            held <= 0;
        end else if (held < RESET_CYCLES) begin
            held <= held + 1;
        end
    end

    assign rst = (held >= RESET_CYCLES);

endmodule

//--- rtl/cpu_pipeline.sv
// three-stage RV32I core top level with Wishbone instruction and data masters
module cpu_pipeline import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output logic  ibus_cyc,
    output logic  ibus_stb,
    output word_t ibus_adr,
    input  word_t ibus_rdata,
    input  logic  ibus_ack,
    output logic  dbus_cyc,
    output logic  dbus_stb,
    output logic  dbus_we,
    output word_t dbus_adr,
    output word_t dbus_wdata,
    input  word_t dbus_rdata,
    input  logic  dbus_ack
);

    logic      redirect;
    word_t     redirect_pc;
    logic      take;
    logic      fetch_valid;
    word_t     fetch_pc;
    word_t     fetch_inst;
    // completing result, written and forwarded in the same cycle
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    issue_if u_issue_bus ();

    inst_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .take        (take),
        .ibus_cyc    (ibus_cyc),
        .ibus_stb    (ibus_stb),
        .ibus_adr    (ibus_adr),
        .ibus_rdata  (ibus_rdata),
        .ibus_ack    (ibus_ack),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    issue_stage u_issue (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .take        (take),
        .redirect    (redirect),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .iss         (u_issue_bus.issue)
    );

    ex_unit u_ex (
        .clk         (clk),
        .rst         (rst),
        .ex          (u_issue_bus.execute),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .dbus_cyc    (dbus_cyc),
        .dbus_stb    (dbus_stb),
        .dbus_we     (dbus_we),
        .dbus_adr    (dbus_adr),
        .dbus_wdata  (dbus_wdata),
        .dbus_rdata  (dbus_rdata),
        .dbus_ack    (dbus_ack)
    );

endmodule

//--- rtl/ex_unit.sv
// execute and write-back: ALU, branch and jal resolution, Wishbone data access
`include "rv_macros.svh"

module ex_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    issue_if.execute  ex,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      redirect,
    output word_t     redirect_pc,
    output logic      dbus_cyc,
    output logic      dbus_stb,
    output logic      dbus_we,
    output word_t     dbus_adr,
    output word_t     dbus_wdata,
    input  word_t     dbus_rdata,
    input  logic      dbus_ack
);

    word_t alu_b;
    word_t alu_res;
    logic  br_taken;
    logic  is_mem;
    // data cycle open
    logic  mem_busy;

    assign alu_b  = ex.use_imm ? ex.imm : ex.op_b;
    assign is_mem = ex.is_load || ex.is_store;

    always_comb begin
        case (ex.alu_op)
            `ALU_ADD:    alu_res = ex.op_a + alu_b;
            `ALU_SUB:    alu_res = ex.op_a - alu_b;
            `ALU_AND:    alu_res = ex.op_a & alu_b;
            `ALU_OR:     alu_res = ex.op_a | alu_b;
            `ALU_XOR:    alu_res = ex.op_a ^ alu_b;
            `ALU_SLT:    alu_res = {31'd0, $signed(ex.op_a) < $signed(alu_b)};
            `ALU_SLTU:   alu_res = {31'd0, ex.op_a < alu_b};
            `ALU_SLL:    alu_res = ex.op_a << alu_b[4:0];
            `ALU_SRL:    alu_res = ex.op_a >> alu_b[4:0];
            `ALU_SRA:    alu_res = $signed(ex.op_a) >>> alu_b[4:0];
            `ALU_PASS_B: alu_res = alu_b;
            default:     alu_res = '0;
        endcase
    end

    always_comb begin
        case (ex.br_cond)
            `BR_EQ:  br_taken = (ex.op_a == ex.op_b);
            `BR_NE:  br_taken = (ex.op_a != ex.op_b);
            `BR_LT:  br_taken = ($signed(ex.op_a) < $signed(ex.op_b));
            `BR_GE:  br_taken = ($signed(ex.op_a) >= $signed(ex.op_b));
            default: br_taken = 1'b0;
        endcase
    end

    // at least one idle cycle between data transfers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            if (dbus_ack) begin
                mem_busy <= 1'b0;
            end
        end else if (ex.valid && is_mem) begin
            mem_busy <= 1'b1;
        end
    end

    assign dbus_cyc   = mem_busy;
    assign dbus_stb   = mem_busy;
    assign dbus_we    = mem_busy && ex.is_store;
    assign dbus_adr   = ex.op_a + ex.imm;
    assign dbus_wdata = ex.op_b;

    // everything but memory finishes in its first cycle
    assign ex.done = ex.valid &&
                     (ex.is_alu || ex.is_branch || ex.is_jal || (mem_busy && dbus_ack));

    assign wb_en   = ex.done && (ex.is_alu || ex.is_jal || ex.is_load);
    assign wb_rd   = ex.rd;
    assign wb_data = ex.is_load ? dbus_rdata : (ex.is_jal ? ex.pc + 32'd4 : alu_res);

    assign redirect    = ex.valid && (ex.is_jal || (ex.is_branch && br_taken));
    assign redirect_pc = ex.pc + ex.imm;

    a_dbus_stb_held: assert property (@(posedge clk) disable iff (!rst)
        dbus_stb && !dbus_ack |=> dbus_stb && dbus_cyc && $stable(dbus_adr));

    a_dbus_we_store: assert property (@(posedge clk) disable iff (!rst)
        dbus_we |-> ex.valid && ex.is_store);

endmodule

//--- rtl/issue_stage.sv
// decode, operand read with forwarding, stall control and the issue/execute register
module issue_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      fetch_valid,
    input  word_t     fetch_pc,
    input  word_t     fetch_inst,
    output logic      take,
    input  logic      redirect,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    issue_if.issue    iss
);

    reg_addr_t rs1, rs2, rd;
    word_t     imm, rs1_data, rs2_data;
    alu_op_t   alu_op;
    br_cond_t  br_cond;
    logic      is_alu, use_imm, is_branch, is_jal, is_load, is_store;
    logic      uses_rs1, uses_rs2, writes_rd;
    logic      stall;
    logic      kind_any;

    // take the result completing in execute this cycle over the file
    function automatic word_t operand(input logic used, input reg_addr_t src, input word_t rf_val);
        if (!used) begin
            return '0;
        end
        if (wb_en && src == wb_rd && src != '0) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    inst_decoder u_decoder (
        .inst      (fetch_inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .alu_op    (alu_op),
        .br_cond   (br_cond),
        .is_alu    (is_alu),
        .use_imm   (use_imm),
        .is_branch (is_branch),
        .is_jal    (is_jal),
        .is_load   (is_load),
        .is_store  (is_store),
        .uses_rs1  (uses_rs1),
        .uses_rs2  (uses_rs2),
        .writes_rd (writes_rd)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_en),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    // execute busy with an unfinished instruction
    assign stall    = iss.valid && !iss.done;
    assign take     = fetch_valid && !stall;
    // unsupported encodings carry no kind flag and become bubbles
    assign kind_any = is_alu || is_branch || is_jal || is_load || is_store;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            iss.valid <= 1'b0;
        end else if (redirect) begin
            iss.valid <= 1'b0;
        end else if (!stall) begin
            iss.valid <= fetch_valid && kind_any;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            iss.pc        <= fetch_pc;
            iss.op_a      <= operand(uses_rs1, rs1, rs1_data);
            iss.op_b      <= operand(uses_rs2, rs2, rs2_data);
            iss.imm       <= imm;
            iss.rd        <= writes_rd ? rd : '0;
            iss.alu_op    <= alu_op;
            iss.br_cond   <= br_cond;
            iss.is_alu    <= is_alu;
            iss.use_imm   <= use_imm;
            iss.is_branch <= is_branch;
            iss.is_jal    <= is_jal;
            iss.is_load   <= is_load;
            iss.is_store  <= is_store;
        end
    end

    a_flush_on_redirect: assert property (@(posedge clk) disable iff (!rst)
        redirect |=> !iss.valid);

endmodule

//--- rtl/reg_file.sv
// integer register file, two asynchronous read ports and one write port
module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            // x0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- rtl/inst_decoder.sv
// RV32I field extraction and operation classification for the issue stage
`include "rv_macros.svh"

module inst_decoder import rv_pkg::*; (
    input  word_t     inst,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm,
    output alu_op_t   alu_op,
    output br_cond_t  br_cond,
    output logic      is_alu,
    output logic      use_imm,
    output logic      is_branch,
    output logic      is_jal,
    output logic      is_load,
    output logic      is_store,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output logic      writes_rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign rd      = inst[11:7];
    assign br_cond = funct3;

    always_comb begin
        imm       = '0;
        alu_op    = `ALU_ADD;
        is_alu    = 1'b0;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        case (opcode)
            `OPC_OP: begin
                // only sub and sra may set funct7 bit 5
                is_alu = (funct7 == 7'b0000000) ||
                         (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? `ALU_SUB : `ALU_ADD;
                    3'b001:  alu_op = `ALU_SLL;
                    3'b010:  alu_op = `ALU_SLT;
                    3'b011:  alu_op = `ALU_SLTU;
                    3'b100:  alu_op = `ALU_XOR;
                    3'b101:  alu_op = funct7[5] ? `ALU_SRA : `ALU_SRL;
                    3'b110:  alu_op = `ALU_OR;
                    default: alu_op = `ALU_AND;
                endcase
            end
            `OPC_OP_IMM: begin
                imm     = {{20{inst[31]}}, inst[31:20]};
                use_imm = 1'b1;
                is_alu  = 1'b1;
                case (funct3)
                    3'b000:  alu_op = `ALU_ADD;
                    3'b010:  alu_op = `ALU_SLT;
                    3'b100:  alu_op = `ALU_XOR;
                    3'b110:  alu_op = `ALU_OR;
                    3'b111:  alu_op = `ALU_AND;
                    // shifts and sltiu are not kept
                    default: is_alu = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                imm     = {inst[31:12], 12'b0};
                alu_op  = `ALU_PASS_B;
                use_imm = 1'b1;
                is_alu  = 1'b1;
            end
            `OPC_LOAD: begin
                imm     = {{20{inst[31]}}, inst[31:20]};
                is_load = (funct3 == 3'b010);
            end
            `OPC_STORE: begin
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                is_store = (funct3 == 3'b010);
            end
            `OPC_BRANCH: begin
                imm       = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                is_branch = (funct3 == `BR_EQ) || (funct3 == `BR_NE) ||
                            (funct3 == `BR_LT) || (funct3 == `BR_GE);
            end
            `OPC_JAL: begin
                imm    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                is_jal = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign uses_rs1  = (is_alu && opcode != `OPC_LUI) || is_branch || is_load || is_store;
    assign uses_rs2  = (is_alu && !use_imm) || is_branch || is_store;
    assign writes_rd = is_alu || is_jal || is_load;

endmodule

//--- rtl/inst_fetch.sv
// program counter and Wishbone instruction master, holding one fetched instruction for issue
`include "rv_macros.svh"

module inst_fetch import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  logic  take,
    output logic  ibus_cyc,
    output logic  ibus_stb,
    output word_t ibus_adr,
    input  word_t ibus_rdata,
    input  logic  ibus_ack,
    output logic  fetch_valid,
    output word_t fetch_pc,
    output word_t fetch_inst
);

    fetch_state_t state;
    word_t        pc;
    logic         can_start;
    word_t        start_pc;

    // a new fetch only once the held instruction is gone
    assign can_start = !fetch_valid || take || redirect;
    assign start_pc  = redirect ? redirect_pc : pc;

    assign ibus_cyc = (state != FETCH_IDLE);
    assign ibus_stb = ibus_cyc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= FETCH_IDLE;
            pc          <= `RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            if (take || redirect) begin
                fetch_valid <= 1'b0;
            end
            case (state)
                FETCH_IDLE: begin
                    if (can_start) begin
                        state <= FETCH_BUSY;
                        pc    <= start_pc + 32'd4;
                    end
                end
                FETCH_BUSY: begin
                    if (ibus_ack) begin
                        state       <= FETCH_IDLE;
                        fetch_valid <= !redirect;
                    end else if (redirect) begin
                        state <= FETCH_DISCARD;
                    end
                    if (redirect) begin
                        pc <= redirect_pc;
                    end
                end
                default: begin
                    // wrong-path cycle still open, drop its data
                    if (ibus_ack) begin
                        state <= FETCH_IDLE;
                    end
                    if (redirect) begin
                        pc <= redirect_pc;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE && can_start) begin
            ibus_adr <= start_pc;
        end
        if (state == FETCH_BUSY && ibus_ack) begin
            fetch_pc   <= ibus_adr;
            fetch_inst <= ibus_rdata;
        end
    end

    a_ibus_stb_cyc: assert property (@(posedge clk) disable iff (!rst)
        ibus_stb && !ibus_ack |=> ibus_stb && ibus_cyc);

    a_ibus_adr_stable: assert property (@(posedge clk) disable iff (!rst)
        ibus_stb && !ibus_ack |=> $stable(ibus_adr));

endmodule

//--- rtl/issue_if.sv
// decoded instruction handed from the issue stage to the execute stage
interface issue_if import rv_pkg::*; ();

    logic      valid;
    word_t     pc;
    word_t     op_a;
    word_t     op_b;
    word_t     imm;
    reg_addr_t rd;
    alu_op_t   alu_op;
    br_cond_t  br_cond;
    logic      is_alu;
    logic      use_imm;
    logic      is_branch;
    logic      is_jal;
    logic      is_load;
    logic      is_store;
    // execute finishes its instruction this cycle
    logic      done;

    modport issue (
        output valid, pc, op_a, op_b, imm, rd, alu_op, br_cond,
        output is_alu, use_imm, is_branch, is_jal, is_load, is_store,
        input  done
    );

    modport execute (
        input  valid, pc, op_a, op_b, imm, rd, alu_op, br_cond,
        input  is_alu, use_imm, is_branch, is_jal, is_load, is_store,
        output done
    );

endinterface

//--- rtl/rv_pkg.sv
// shared types of the core, imported by every RTL module
`include "rv_macros.svh"

package rv_pkg;

    // data, addresses and instruction words
    typedef logic [`XLEN-1:0] word_t;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [3:0] alu_op_t;

    // funct3 of a branch
    typedef logic [2:0] br_cond_t;

    // instruction bus master state
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_BUSY,
        FETCH_DISCARD
    } fetch_state_t;

endpackage

//--- rtl/rv_macros.svh
// core-wide constants for widths, opcodes and operation codes; include where they are needed
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// alu operations
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLT     4'd5
`define ALU_SLTU    4'd6
`define ALU_SLL     4'd7
`define ALU_SRL     4'd8
`define ALU_SRA     4'd9
`define ALU_PASS_B  4'd10

// branch conditions, same as funct3
`define BR_EQ       3'b000
`define BR_NE       3'b001
`define BR_LT       3'b100
`define BR_GE       3'b101

`endif
